/* common/csr_pkg.sv */
package csr_pkg;

    typedef logic [13:0] csr_num_t;

    localparam csr_num_t CSR_CRMD     = 14'h000;
    localparam csr_num_t CSR_PRMD     = 14'h001;
    localparam csr_num_t CSR_ECFG     = 14'h004;
    localparam csr_num_t CSR_ESTAT    = 14'h005;
    localparam csr_num_t CSR_ERA      = 14'h006;
    localparam csr_num_t CSR_BADV     = 14'h007;
    localparam csr_num_t CSR_EENTRY   = 14'h00c;
    localparam csr_num_t CSR_SAVE0    = 14'h030;
    localparam csr_num_t CSR_SAVE1    = 14'h031;
    localparam csr_num_t CSR_SAVE2    = 14'h032;
    localparam csr_num_t CSR_SAVE3    = 14'h033;
    localparam csr_num_t CSR_TCFG     = 14'h041;
    localparam csr_num_t CSR_TVAL     = 14'h042;
    localparam csr_num_t CSR_TICLR    = 14'h044;
    localparam csr_num_t CSR_DMW_BASE = 14'h180;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    localparam ecode_t    ECODE_INT     = 6'h00;
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // status and enable width: 2 sw, 8 hw, 1 rsvd, timer, ipi
    localparam int INT_BITS = 13;

    // writable bits per register
    localparam logic [31:0] CRMD_WMASK  = 32'h0000_01ff;
    localparam logic [31:0] PRMD_WMASK  = 32'h0000_0007;
    localparam logic [31:0] ECFG_WMASK  = 32'h0000_1bff;
    localparam logic [31:0] ESTAT_WMASK = 32'h0000_0003;

    // da set, everything else clear
    localparam logic [31:0] CRMD_RESET  = 32'h0000_0008;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef union packed {
        logic [31:0] raw;
        crmd_t       crmd;
        tcfg_t       tcfg;
    } csr_word_u;

    typedef struct packed {
        logic        we;
        csr_num_t    wnum;
        csr_word_u   wvalue;
        logic [31:0] wmask;
    } csr_wr_t;

    typedef struct packed {
        logic        ex;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } exc_t;

    function automatic logic [31:0] masked_wr(logic [31:0] old, logic [31:0] value,
                                              logic [31:0] mask);
        return (old & ~mask) | (value & mask);
    endfunction

endpackage

/* common/mmu_pkg.sv */
package mmu_pkg;

    localparam int DMW_COUNT = 2;

    // vseg, pseg, mat, plv3, plv0
    localparam logic [31:0] DMW_WMASK = 32'hee00_0039;

    // laid out as the DMW csr word
    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsvd0;
        logic [2:0]  pseg;
        logic [18:0] rsvd1;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  rsvd2;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        logic       fetch_hit;
        logic       mem_hit;
        logic [2:0] pseg;
    } dmw_hit_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        miss;
    } xlate_t;

endpackage

/* hdl/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic                                      clk,
    input  logic                                      reset,
    input  csr_pkg::csr_wr_t                          csr_wr,
    input  csr_pkg::csr_num_t                         csr_rnum,
    output csr_pkg::csr_word_u                        csr_rvalue,
    input  csr_pkg::exc_t                             exc,
    input  logic                                      ertn,
    input  logic [7:0]                                hw_int,
    input  logic                                      ipi_int,
    input  csr_pkg::tcfg_t                            tcfg,
    input  logic [31:0]                               tval,
    input  logic                                      ti,
    input  mmu_pkg::dmw_t [mmu_pkg::DMW_COUNT-1:0]    dmw,
    output csr_pkg::crmd_t                            crmd,
    output logic [31:0]                               ex_entry,
    output logic [31:0]                               ex_ra,
    output logic                                      has_int
);

    logic [1:0]                     prmd_pplv;
    logic                           prmd_pie;
    logic [csr_pkg::INT_BITS-1:0]   ecfg_lie;
    logic [1:0]                     is_sw;
    logic [7:0]                     is_hw;
    logic                           is_ipi;
    logic [csr_pkg::INT_BITS-1:0]   estat_is;
    csr_pkg::ecode_t                estat_ecode;
    csr_pkg::esubcode_t             estat_esubcode;
    logic [31:0]                    era;
    logic [31:0]                    badv;
    logic [25:0]                    eentry_va;
    logic [31:0]                    save [4];

    csr_pkg::csr_word_u             crmd_wr;
    logic [31:0]                    prmd_wr;
    logic [31:0]                    ecfg_wr;
    logic [31:0]                    estat_wr;
    logic [31:0]                    eentry_wr;
    logic                           ex_addr_err;

    function automatic logic wr_sel(csr_pkg::csr_num_t num);
        return csr_wr.we && (csr_wr.wnum == num);
    endfunction

    assign crmd_wr.raw = csr_pkg::masked_wr(crmd, csr_wr.wvalue.raw,
                                            csr_wr.wmask & csr_pkg::CRMD_WMASK);
    assign prmd_wr     = csr_pkg::masked_wr({29'b0, prmd_pie, prmd_pplv}, csr_wr.wvalue.raw,
                                            csr_wr.wmask & csr_pkg::PRMD_WMASK);
    assign ecfg_wr     = csr_pkg::masked_wr({19'b0, ecfg_lie}, csr_wr.wvalue.raw,
                                            csr_wr.wmask & csr_pkg::ECFG_WMASK);
    assign estat_wr    = csr_pkg::masked_wr({30'b0, is_sw}, csr_wr.wvalue.raw,
                                            csr_wr.wmask & csr_pkg::ESTAT_WMASK);
    assign eentry_wr   = csr_pkg::masked_wr({eentry_va, 6'b0}, csr_wr.wvalue.raw,
                                            csr_wr.wmask);

    // exception entry wins over ertn and csr writes
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= csr_pkg::crmd_t'(csr_pkg::CRMD_RESET);
        end else if (exc.ex) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (ertn) begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end else if (wr_sel(csr_pkg::CSR_CRMD)) begin
            crmd <= crmd_wr.crmd;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            prmd_pplv <= crmd.plv;
            prmd_pie  <= crmd.ie;
        end else if (wr_sel(csr_pkg::CSR_PRMD)) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            is_sw    <= 2'b0;
            is_hw    <= 8'b0;
            is_ipi   <= 1'b0;
        end else begin
            if (wr_sel(csr_pkg::CSR_ECFG)) begin
                ecfg_lie <= ecfg_wr[csr_pkg::INT_BITS-1:0];
            end
            if (wr_sel(csr_pkg::CSR_ESTAT)) begin
                is_sw <= estat_wr[1:0];
            end
            is_hw  <= hw_int;
            is_ipi <= ipi_int;
        end
    end

    // timer bit comes straight from the timer, bit 10 reserved
    assign estat_is = {is_ipi, ti, 1'b0, is_hw, is_sw};

    assign ex_addr_err = (exc.ecode == csr_pkg::ECODE_ADE) || (exc.ecode == csr_pkg::ECODE_ALE);

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
            era            <= exc.pc;
        end else if (wr_sel(csr_pkg::CSR_ERA)) begin
            era <= csr_pkg::masked_wr(era, csr_wr.wvalue.raw, csr_wr.wmask);
        end

        if (exc.ex && ex_addr_err) begin
            // fetch faults have no data address
            if (exc.ecode == csr_pkg::ECODE_ADE && exc.esubcode == csr_pkg::ESUBCODE_ADEF) begin
                badv <= exc.pc;
            end else begin
                badv <= exc.vaddr;
            end
        end else if (wr_sel(csr_pkg::CSR_BADV)) begin
            badv <= csr_pkg::masked_wr(badv, csr_wr.wvalue.raw, csr_wr.wmask);
        end

        if (wr_sel(csr_pkg::CSR_EENTRY)) begin
            eentry_va <= eentry_wr[31:6];
        end

        for (int i = 0; i < 4; i++) begin
            if (wr_sel(csr_pkg::csr_num_t'(csr_pkg::CSR_SAVE0 + i))) begin
                save[i] <= csr_pkg::masked_wr(save[i], csr_wr.wvalue.raw, csr_wr.wmask);
            end
        end
    end

    always_comb begin
        csr_rvalue.raw = 32'b0;
        case (csr_rnum)
            csr_pkg::CSR_CRMD:   csr_rvalue.crmd = crmd;
            csr_pkg::CSR_PRMD:   csr_rvalue.raw = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   csr_rvalue.raw = {19'b0, ecfg_lie};
            csr_pkg::CSR_ESTAT:  csr_rvalue.raw = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            csr_pkg::CSR_ERA:    csr_rvalue.raw = era;
            csr_pkg::CSR_BADV:   csr_rvalue.raw = badv;
            csr_pkg::CSR_EENTRY: csr_rvalue.raw = {eentry_va, 6'b0};
            csr_pkg::CSR_SAVE0:  csr_rvalue.raw = save[0];
            csr_pkg::CSR_SAVE1:  csr_rvalue.raw = save[1];
            csr_pkg::CSR_SAVE2:  csr_rvalue.raw = save[2];
            csr_pkg::CSR_SAVE3:  csr_rvalue.raw = save[3];
            csr_pkg::CSR_TCFG:   csr_rvalue.tcfg = tcfg;
            csr_pkg::CSR_TVAL:   csr_rvalue.raw = tval;
            csr_pkg::CSR_TICLR:  csr_rvalue.raw = 32'b0;
            default: begin
                for (int k = 0; k < mmu_pkg::DMW_COUNT; k++) begin
                    if (csr_rnum == csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + k)) begin
                        csr_rvalue.raw = dmw[k];
                    end
                end
            end
        endcase
    end

    assign ex_entry = {eentry_va, 6'b0};
    assign ex_ra    = era;
    assign has_int  = (|(estat_is[11:0] & ecfg_lie[11:0])) && crmd.ie;

    // writeback never flags an exception and ertn in the same cycle
    assert property (@(posedge clk) disable iff (reset) !(exc.ex && ertn));

endmodule

/* hdl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_wr_t  csr_wr,
    output csr_pkg::tcfg_t    tcfg,
    output logic [31:0]       tval,
    output logic              ti
);

    csr_pkg::csr_word_u tcfg_next;
    logic               tcfg_we;
    logic               ticlr_we;
    logic               load;
    logic [31:0]        cnt;

    assign tcfg_we  = csr_wr.we && (csr_wr.wnum == csr_pkg::CSR_TCFG);
    assign ticlr_we = csr_wr.we && (csr_wr.wnum == csr_pkg::CSR_TICLR)
                      && csr_wr.wmask[0] && csr_wr.wvalue.raw[0];

    // value tcfg takes after this write
    assign tcfg_next.raw = csr_pkg::masked_wr(tcfg, csr_wr.wvalue.raw, csr_wr.wmask);
    assign load          = tcfg_we && tcfg_next.tcfg.en;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_we) begin
            tcfg <= tcfg_next.tcfg;
        end
    end

    // all ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (load) begin
            cnt <= {tcfg_next.tcfg.initval, 2'b0};
        end else if (tcfg.en && cnt != '1) begin
            if (cnt == 32'b0 && tcfg.periodic) begin
                cnt <= {tcfg.initval, 2'b0};
            end else begin
                cnt <= cnt - 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (tcfg.en && cnt == 32'b0) begin
            ti <= 1'b1;
        end else if (ticlr_we) begin
            ti <= 1'b0;
        end
    end

    assign tval = cnt;

    // a disabled timer holds its count until reloaded
    assert property (@(posedge clk) disable iff (reset)
        (!tcfg.en && !load) |=> $stable(cnt));

endmodule

/* mmu/dmw_window.sv */
`timescale 1ns/1ps

module dmw_window #(
    parameter int WIN_INDEX = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::crmd_t     crmd,
    input  logic [31:0]        fetch_vaddr,
    input  logic [31:0]        mem_vaddr,
    output mmu_pkg::dmw_t      dmw,
    output mmu_pkg::dmw_hit_t  hit
);

    logic sel;
    logic plv_ok;

    assign sel = csr_wr.we
                 && (csr_wr.wnum == csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + WIN_INDEX));

    always_ff @(posedge clk) begin
        if (reset) begin
            dmw <= '0;
        end else if (sel) begin
            dmw <= csr_pkg::masked_wr(dmw, csr_wr.wvalue.raw,
                                      csr_wr.wmask & mmu_pkg::DMW_WMASK);
        end
    end

    // only levels 0 and 3 can be enabled
    assign plv_ok = (dmw.plv0 && crmd.plv == 2'd0) || (dmw.plv3 && crmd.plv == 2'd3);

    assign hit.fetch_hit = plv_ok && (fetch_vaddr[31:29] == dmw.vseg);
    assign hit.mem_hit   = plv_ok && (mem_vaddr[31:29] == dmw.vseg);
    assign hit.pseg      = dmw.pseg;

endmodule

/* mmu/addr_xlate.sv */
`timescale 1ns/1ps

module addr_xlate (
    input  csr_pkg::crmd_t                                crmd,
    input  mmu_pkg::dmw_hit_t [mmu_pkg::DMW_COUNT-1:0]    hits,
    input  logic [31:0]                                   fetch_vaddr,
    input  logic [31:0]                                   mem_vaddr,
    output mmu_pkg::xlate_t                               fetch_xlate,
    output mmu_pkg::xlate_t                               mem_xlate
);

    logic                                  da_mode;
    logic                                  pg_mode;
    logic [mmu_pkg::DMW_COUNT-1:0]         fetch_hits;
    logic [mmu_pkg::DMW_COUNT-1:0]         mem_hits;
    logic [mmu_pkg::DMW_COUNT-1:0][2:0]    segs;

    function automatic mmu_pkg::xlate_t translate(
        logic [31:0]                          vaddr,
        logic [mmu_pkg::DMW_COUNT-1:0]        hit_vec,
        logic [mmu_pkg::DMW_COUNT-1:0][2:0]   seg_vec,
        logic                                 da,
        logic                                 pg
    );
        mmu_pkg::xlate_t res;
        res = '0;
        if (da) begin
            res.paddr = vaddr;
        end else if (pg) begin
            res.miss = ~|hit_vec;
            // walk down so the lowest window ends up winning
            for (int i = mmu_pkg::DMW_COUNT - 1; i >= 0; i--) begin
                if (hit_vec[i]) begin
                    res.paddr = {seg_vec[i], vaddr[28:0]};
                end
            end
        end
        return res;
    endfunction

    assign da_mode = crmd.da && !crmd.pg;
    assign pg_mode = !crmd.da && crmd.pg;

    always_comb begin
        for (int i = 0; i < mmu_pkg::DMW_COUNT; i++) begin
            fetch_hits[i] = hits[i].fetch_hit;
            mem_hits[i]   = hits[i].mem_hit;
            segs[i]       = hits[i].pseg;
        end
    end

    always_comb begin
        fetch_xlate = translate(fetch_vaddr, fetch_hits, segs, da_mode, pg_mode);
        mem_xlate   = translate(mem_vaddr, mem_hits, segs, da_mode, pg_mode);
    end

endmodule

/* hdl/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_wr_t    csr_wr,
    input  csr_pkg::csr_num_t   csr_rnum,
    output csr_pkg::csr_word_u  csr_rvalue,
    input  csr_pkg::exc_t       exc,
    input  logic                ertn,
    input  logic [7:0]          hw_int,
    input  logic                ipi_int,
    output logic [31:0]         ex_entry,
    output logic [31:0]         ex_ra,
    output logic                has_int,
    input  logic [31:0]         fetch_vaddr,
    input  logic [31:0]         mem_vaddr,
    output mmu_pkg::xlate_t     fetch_xlate,
    output mmu_pkg::xlate_t     mem_xlate
);

    csr_pkg::crmd_t                                crmd;
    csr_pkg::tcfg_t                                tcfg;
    logic [31:0]                                   tval;
    logic                                          ti;
    mmu_pkg::dmw_t     [mmu_pkg::DMW_COUNT-1:0]    dmw;
    mmu_pkg::dmw_hit_t [mmu_pkg::DMW_COUNT-1:0]    hits;

    csr_file i_csr_file (
        .clk        (clk),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .csr_rnum   (csr_rnum),
        .csr_rvalue (csr_rvalue),
        .exc        (exc),
        .ertn       (ertn),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti         (ti),
        .dmw        (dmw),
        .crmd       (crmd),
        .ex_entry   (ex_entry),
        .ex_ra      (ex_ra),
        .has_int    (has_int)
    );

    csr_timer i_csr_timer (
        .clk    (clk),
        .reset  (reset),
        .csr_wr (csr_wr),
        .tcfg   (tcfg),
        .tval   (tval),
        .ti     (ti)
    );

    for (genvar w = 0; w < mmu_pkg::DMW_COUNT; w++) begin : g_dmw
        dmw_window #(
            .WIN_INDEX (w)
        ) i_dmw_window (
            .clk         (clk),
            .reset       (reset),
            .csr_wr      (csr_wr),
            .crmd        (crmd),
            .fetch_vaddr (fetch_vaddr),
            .mem_vaddr   (mem_vaddr),
            .dmw         (dmw[w]),
            .hit         (hits[w])
        );
    end

    addr_xlate i_addr_xlate (
        .crmd        (crmd),
        .hits        (hits),
        .fetch_vaddr (fetch_vaddr),
        .mem_vaddr   (mem_vaddr),
        .fetch_xlate (fetch_xlate),
        .mem_xlate   (mem_xlate)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* bench/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int          RESET_CYCLES = 16;
    localparam int unsigned SEED         = 32'h602b_2d09;

    logic                clk;
    logic                reset;
    csr_pkg::csr_wr_t    csr_wr;
    csr_pkg::csr_num_t   csr_rnum;
    csr_pkg::csr_word_u  csr_rvalue;
    csr_pkg::exc_t       exc;
    logic                ertn;
    logic [7:0]          hw_int;
    logic                ipi_int;
    logic [31:0]         ex_entry;
    logic [31:0]         ex_ra;
    logic                has_int;
    logic [31:0]         fetch_vaddr;
    logic [31:0]         mem_vaddr;
    mmu_pkg::xlate_t     fetch_xlate;
    mmu_pkg::xlate_t     mem_xlate;

    logic [31:0]         eentry_ref;
    int unsigned         seed_ret;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    csr_unit i_csr_unit (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (csr_wr),
        .csr_rnum    (csr_rnum),
        .csr_rvalue  (csr_rvalue),
        .exc         (exc),
        .ertn        (ertn),
        .hw_int      (hw_int),
        .ipi_int     (ipi_int),
        .ex_entry    (ex_entry),
        .ex_ra       (ex_ra),
        .has_int     (has_int),
        .fetch_vaddr (fetch_vaddr),
        .mem_vaddr   (mem_vaddr),
        .fetch_xlate (fetch_xlate),
        .mem_xlate   (mem_xlate)
    );

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input csr_pkg::csr_word_u got,
                              input csr_pkg::csr_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
            abort_run();
        end
    endtask

    task automatic check_xlate(input string name, input mmu_pkg::xlate_t got,
                               input mmu_pkg::xlate_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got paddr %h miss %b expected paddr %h miss %b",
                     $time, name, got.paddr, got.miss, exp.paddr, exp.miss);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // write is taken at the second edge
    task automatic write_csr(input csr_pkg::csr_num_t num, input logic [31:0] value,
                             input logic [31:0] mask);
        @(posedge clk);
        csr_wr <= {1'b1, num, value, mask};
        @(posedge clk);
        csr_wr.we <= 1'b0;
    endtask

    task automatic expect_csr(input csr_pkg::csr_num_t num, input logic [31:0] exp,
                              input string name);
        @(posedge clk);
        csr_rnum <= num;
        @(negedge clk);
        check_word(name, csr_rvalue, exp);
    endtask

    task automatic pulse_exc(input csr_pkg::ecode_t ecode, input csr_pkg::esubcode_t esub,
                             input logic [31:0] pc, input logic [31:0] vaddr);
        @(posedge clk);
        exc <= {1'b1, ecode, esub, pc, vaddr};
        @(posedge clk);
        exc.ex <= 1'b0;
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        ertn <= 1'b1;
        @(posedge clk);
        ertn <= 1'b0;
    endtask

    task automatic wait_has_int(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (has_int !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (has_int !== level) begin
            $display("timeout: %s not seen within %0d cycles", what, limit);
            abort_run();
        end
    endtask

    // csr_rnum must already select the register
    task automatic wait_read_value(input logic [31:0] value, input int limit,
                                   input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (csr_rvalue.raw !== value && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (csr_rvalue.raw !== value) begin
            $display("timeout: %s not seen within %0d cycles", what, limit);
            abort_run();
        end
    endtask

    task automatic expect_xlate(input logic [31:0] fva, input logic [31:0] mva,
                                input mmu_pkg::xlate_t exp_f, input mmu_pkg::xlate_t exp_m);
        @(posedge clk);
        fetch_vaddr <= fva;
        mem_vaddr   <= mva;
        @(negedge clk);
        check_xlate("fetch_xlate", fetch_xlate, exp_f);
        check_xlate("mem_xlate", mem_xlate, exp_m);
    endtask

    task automatic test_reset_state();
        logic [31:0] va;
        logic [31:0] vb;
        va = $urandom;
        vb = $urandom;
        expect_csr(csr_pkg::CSR_CRMD, 32'h0000_0008, "crmd after reset");
        expect_csr(csr_pkg::CSR_TVAL, 32'hffff_ffff, "tval after reset");
        check_bit("has_int after reset", has_int, 1'b0);
        expect_xlate(va, vb, {va, 1'b0}, {vb, 1'b0});
    endtask

    task automatic test_masked_writes();
        csr_pkg::csr_num_t nums [6];
        logic [31:0]       ref_val;
        logic [31:0]       value;
        logic [31:0]       mask;
        logic [31:0]       keep;
        nums[0] = csr_pkg::CSR_SAVE0;
        nums[1] = csr_pkg::CSR_SAVE1;
        nums[2] = csr_pkg::CSR_SAVE2;
        nums[3] = csr_pkg::CSR_SAVE3;
        nums[4] = csr_pkg::CSR_ERA;
        nums[5] = csr_pkg::CSR_EENTRY;
        for (int i = 0; i < 6; i++) begin
            // eentry is 64-byte aligned
            keep = (nums[i] == csr_pkg::CSR_EENTRY) ? 32'hffff_ffc0 : 32'hffff_ffff;
            value = $urandom;
            ref_val = value & keep;
            write_csr(nums[i], value, 32'hffff_ffff);
            expect_csr(nums[i], ref_val, $sformatf("csr %h full write", nums[i]));
            repeat (4) begin
                value = $urandom;
                mask = $urandom;
                ref_val = ((ref_val & ~mask) | (value & mask)) & keep;
                write_csr(nums[i], value, mask);
                expect_csr(nums[i], ref_val, $sformatf("csr %h masked write", nums[i]));
            end
            if (nums[i] == csr_pkg::CSR_EENTRY) begin
                eentry_ref = ref_val;
            end
        end
    endtask

    task automatic test_exception();
        logic [31:0] pc;
        logic [31:0] va;
        pc = $urandom & 32'hffff_fffc;
        va = $urandom;
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
        expect_csr(csr_pkg::CSR_CRMD, 32'h0000_000f, "crmd before exception");
        pulse_exc(csr_pkg::ECODE_ALE, 9'h0, pc, va);
        expect_csr(csr_pkg::CSR_PRMD, 32'h0000_0007, "prmd after entry");
        expect_csr(csr_pkg::CSR_CRMD, 32'h0000_0008, "crmd after entry");
        expect_csr(csr_pkg::CSR_ERA, pc, "era after entry");
        expect_csr(csr_pkg::CSR_ESTAT, {1'b0, 9'h0, csr_pkg::ECODE_ALE, 16'h0}, "estat ale");
        expect_csr(csr_pkg::CSR_BADV, va, "badv ale");
        check_word("ex_entry", ex_entry, eentry_ref);
        check_word("ex_ra", ex_ra, pc);
        pulse_ertn();
        expect_csr(csr_pkg::CSR_CRMD, 32'h0000_000f, "crmd after ertn");

        pc = $urandom & 32'hffff_fffc;
        va = $urandom;
        pulse_exc(csr_pkg::ECODE_ADE, csr_pkg::ESUBCODE_ADEF, pc, va);
        expect_csr(csr_pkg::CSR_BADV, pc, "badv adef");
        expect_csr(csr_pkg::CSR_ESTAT, {1'b0, csr_pkg::ESUBCODE_ADEF, csr_pkg::ECODE_ADE, 16'h0},
                   "estat adef");
        pulse_ertn();
        expect_csr(csr_pkg::CSR_CRMD, 32'h0000_000f, "crmd after second ertn");
    endtask

    task automatic test_timer_int();
        logic [29:0] initval;
        int          limit;
        initval = 30'(($urandom % 16) + 4);
        limit = int'(initval) * 4 + 8;
        // ie is still set from the ertn
        write_csr(csr_pkg::CSR_ECFG, 32'h0000_0800, 32'hffff_ffff);
        write_csr(csr_pkg::CSR_TCFG, {initval, 1'b0, 1'b1}, 32'hffff_ffff);
        wait_has_int(1'b1, limit, "one-shot timer interrupt");
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        @(negedge clk);
        check_bit("has_int after ticlr", has_int, 1'b0);

        write_csr(csr_pkg::CSR_TCFG, {initval, 1'b1, 1'b1}, 32'hffff_ffff);
        @(posedge clk);
        csr_rnum <= csr_pkg::CSR_TVAL;
        wait_read_value(32'h0, limit, "periodic tval reaching zero");
        @(negedge clk);
        check_word("tval reload", csr_rvalue, {initval, 2'b00});

        write_csr(csr_pkg::CSR_TCFG, 32'h0, 32'hffff_ffff);
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        write_csr(csr_pkg::CSR_ECFG, 32'h0, 32'hffff_ffff);
        @(negedge clk);
        check_bit("has_int after timer off", has_int, 1'b0);
    endtask

    task automatic test_hw_sw_int();
        int k;
        k = $urandom % 8;
        write_csr(csr_pkg::CSR_ECFG, 32'h1 << (k + 2), 32'hffff_ffff);
        @(posedge clk);
        hw_int <= 8'h1 << k;
        @(negedge clk);
        check_bit("has_int before hw sample", has_int, 1'b0);
        @(negedge clk);
        check_bit("has_int from hw_int", has_int, 1'b1);
        write_csr(csr_pkg::CSR_ECFG, 32'h0, 32'hffff_ffff);
        @(negedge clk);
        check_bit("has_int after lie clear", has_int, 1'b0);
        @(posedge clk);
        hw_int <= 8'h0;

        k = $urandom % 2;
        write_csr(csr_pkg::CSR_ECFG, 32'h1 << k, 32'hffff_ffff);
        write_csr(csr_pkg::CSR_ESTAT, 32'h1 << k, 32'h3);
        @(negedge clk);
        check_bit("has_int from sw bit", has_int, 1'b1);
        write_csr(csr_pkg::CSR_ECFG, 32'h0, 32'hffff_ffff);
        @(negedge clk);
        check_bit("has_int after sw lie clear", has_int, 1'b0);
        write_csr(csr_pkg::CSR_ESTAT, 32'h0, 32'h3);
    endtask

    task automatic test_windows();
        logic [2:0]    seg_a;
        logic [2:0]    seg_b;
        logic [2:0]    seg_c;
        logic [2:0]    pseg0;
        logic [2:0]    pseg1;
        logic [28:0]   off_f;
        logic [28:0]   off_m;
        mmu_pkg::dmw_t win0;
        mmu_pkg::dmw_t win1;
        mmu_pkg::dmw_t win1_ovl;
        seg_a = 3'($urandom);
        seg_b = seg_a + 3'd1;
        seg_c = seg_a + 3'd2;
        pseg0 = 3'($urandom);
        pseg1 = pseg0 ^ 3'b101;
        off_f = 29'($urandom);
        off_m = 29'($urandom);
        win0 = '0;
        win0.vseg = seg_a;
        win0.pseg = pseg0;
        win0.plv0 = 1'b1;
        win1 = '0;
        win1.vseg = seg_b;
        win1.pseg = pseg1;
        win1.plv0 = 1'b1;
        win1.plv3 = 1'b1;
        win1_ovl = win1;
        win1_ovl.vseg = seg_a;

        write_csr(csr_pkg::CSR_DMW_BASE, win0, 32'hffff_ffff);
        write_csr(csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + 1), win1, 32'hffff_ffff);
        expect_csr(csr_pkg::CSR_DMW_BASE, win0, "dmw0 readback");
        expect_csr(csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + 1), win1, "dmw1 readback");

        // paged mode at level 0
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_0010, 32'h0000_001f);
        expect_xlate({seg_a, off_f}, {seg_b, off_m}, {pseg0, off_f, 1'b0},
                     {pseg1, off_m, 1'b0});
        expect_xlate({seg_b, off_f}, {seg_a, off_m}, {pseg1, off_f, 1'b0},
                     {pseg0, off_m, 1'b0});

        // both windows on seg_a, window 0 has priority
        write_csr(csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + 1), win1_ovl, 32'hffff_ffff);
        expect_xlate({seg_a, off_f}, {seg_a, off_m}, {pseg0, off_f, 1'b0},
                     {pseg0, off_m, 1'b0});
        write_csr(csr_pkg::csr_num_t'(csr_pkg::CSR_DMW_BASE + 1), win1, 32'hffff_ffff);

        // level 3 is not allowed in window 0
        write_csr(csr_pkg::CSR_CRMD, 32'h0000_0003, 32'h0000_0003);
        expect_xlate({seg_a, off_f}, {seg_b, off_m}, {32'h0, 1'b1}, {pseg1, off_m, 1'b0});

        expect_xlate({seg_c, off_f}, {seg_c, off_m}, {32'h0, 1'b1}, {32'h0, 1'b1});
    endtask

    initial begin
        seed_ret    = $urandom(SEED);
        reset       = 1'b1;
        csr_wr      = '0;
        csr_rnum    = '0;
        exc         = '0;
        ertn        = 1'b0;
        hw_int      = 8'h0;
        ipi_int     = 1'b0;
        fetch_vaddr = 32'h0;
        mem_vaddr   = 32'h0;
        eentry_ref  = 32'h0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_masked_writes();
        test_exception();
        test_timer_int();
        test_hw_sw_int();
        test_windows();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* vlog.f */
common/csr_pkg.sv
common/mmu_pkg.sv
hdl/csr_file.sv
hdl/csr_timer.sv
mmu/dmw_window.sv
mmu/addr_xlate.sv
hdl/csr_unit.sv
bench/tb_clock.sv
bench/csr_unit_tb.sv
